//--- design/mac_fifo_pkg.sv
package mac_fifo_pkg;

    // Stream widths, user side and MAC side alike
    localparam int data_w = 64;
    localparam int keep_w = 8;

    // Frame FIFO geometry
    localparam int fifo_addr_w = 6;
    localparam int fifo_depth  = 64;

    // One beat of payload
    typedef logic [data_w-1:0] data_t;

    // Byte enables, one per data byte
    typedef logic [keep_w-1:0] keep_t;

    // Pointers carry one wrap bit above the address
    // so that a full FIFO differs from an empty one
    typedef logic [fifo_addr_w:0] ptr_t;

    // Stored word, packed as {data, keep, last}
    typedef logic [data_w+keep_w:0] fifo_word_t;

endpackage

//--- design/fifo_ram.sv
`timescale 1ns/10ps

module fifo_ram (
    input  logic                                 logic_clk,
    input  logic                                 tx_clk,
    input  logic                                 wr_en,
    input  logic [mac_fifo_pkg::fifo_addr_w-1:0] wr_addr,
    input  mac_fifo_pkg::fifo_word_t             wr_word,
    input  logic [mac_fifo_pkg::fifo_addr_w-1:0] rd_addr,
    output mac_fifo_pkg::fifo_word_t             rd_word
);
    import mac_fifo_pkg::*;

    fifo_word_t mem [fifo_depth];

    // Write port in the user clock
    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Registered read in the MAC clock, block RAM style
    always_ff @(posedge tx_clk) begin
        rd_word <= mem[rd_addr];
    end

endmodule

//--- design/gray_ptr_sync.sv
`timescale 1ns/10ps

module gray_ptr_sync (
    input  logic               dst_clk,
    input  logic               dst_rst,
    input  mac_fifo_pkg::ptr_t ptr_gray,
    output mac_fifo_pkg::ptr_t ptr_bin
);
    import mac_fifo_pkg::*;

    ptr_t meta_q;
    ptr_t sync_q;

    // Two flop synchronizer, only one bit changes per step in Gray code
    always_ff @(posedge dst_clk or posedge dst_rst) begin
        if (dst_rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= ptr_gray;
            sync_q <= meta_q;
        end
    end

    // Gray to binary, MSB passes straight through
    always_comb begin
        ptr_bin[fifo_addr_w] = sync_q[fifo_addr_w];
        for (int i = fifo_addr_w - 1; i >= 0; i--) begin
            ptr_bin[i] = ptr_bin[i+1] ^ sync_q[i];
        end
    end

endmodule

//--- design/frame_fifo_wr.sv
`timescale 1ns/10ps

module frame_fifo_wr (
    input  logic                                 logic_clk,
    input  logic                                 logic_rst,
    input  mac_fifo_pkg::data_t                  tx_axis_tdata,
    input  mac_fifo_pkg::keep_t                  tx_axis_tkeep,
    input  logic                                 tx_axis_tvalid,
    output logic                                 tx_axis_tready,
    input  logic                                 tx_axis_tlast,
    input  logic                                 tx_axis_tuser,
    input  mac_fifo_pkg::ptr_t                   rd_ptr_sync,
    output mac_fifo_pkg::ptr_t                   wr_ptr_gray,
    output logic                                 ram_wr_en,
    output logic [mac_fifo_pkg::fifo_addr_w-1:0] ram_wr_addr,
    output mac_fifo_pkg::fifo_word_t             ram_wr_word,
    output logic                                 good_frame,
    output logic                                 bad_frame,
    output logic                                 overflow
);
    import mac_fifo_pkg::*;

    ptr_t wr_ptr;
    ptr_t commit_ptr;
    ptr_t wr_ptr_next;
    ptr_t commit_ptr_next;
    ptr_t frame_len;
    ptr_t frame_len_next;
    ptr_t used_next;
    logic drop_mode;
    logic drop_next;
    logic beat;
    logic frame_full;
    logic good_next;
    logic bad_next;
    logic overflow_next;
    logic ready_next;

    assign beat       = tx_axis_tvalid && tx_axis_tready;
    assign frame_len  = wr_ptr - commit_ptr;
    assign frame_full = frame_len == ptr_t'(fifo_depth);

    // Beats of a dropped or oversized frame never reach the RAM
    assign ram_wr_en   = beat && !drop_mode && !frame_full;
    assign ram_wr_addr = wr_ptr[fifo_addr_w-1:0];
    assign ram_wr_word = {tx_axis_tdata, tx_axis_tkeep, tx_axis_tlast};

    always_comb begin
        wr_ptr_next     = wr_ptr;
        commit_ptr_next = commit_ptr;
        drop_next       = drop_mode;
        good_next       = 1'b0;
        bad_next        = 1'b0;
        overflow_next   = 1'b0;
        if (beat) begin
            if (drop_mode) begin
                // Swallow the tail of an oversized frame
                if (tx_axis_tlast) begin
                    drop_next = 1'b0;
                end
            end else if (frame_full) begin
                // Frame cannot fit, throw away what was written
                overflow_next = 1'b1;
                wr_ptr_next   = commit_ptr;
                drop_next     = !tx_axis_tlast;
            end else begin
                wr_ptr_next = wr_ptr + ptr_t'(1);
                if (tx_axis_tlast) begin
                    if (tx_axis_tuser) begin
                        bad_next    = 1'b1;
                        wr_ptr_next = commit_ptr;
                    end else begin
                        good_next       = 1'b1;
                        commit_ptr_next = wr_ptr + ptr_t'(1);
                    end
                end
            end
        end
    end

    // Space check against the read side, stale read pointer only errs safe
    assign used_next      = wr_ptr_next - rd_ptr_sync;
    assign frame_len_next = wr_ptr_next - commit_ptr_next;
    assign ready_next     = (used_next != ptr_t'(fifo_depth)) ||
                            (frame_len_next == ptr_t'(fifo_depth)) ||
                            drop_next;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr         <= '0;
            commit_ptr     <= '0;
            wr_ptr_gray    <= '0;
            drop_mode      <= 1'b0;
            tx_axis_tready <= 1'b0;
            good_frame     <= 1'b0;
            bad_frame      <= 1'b0;
            overflow       <= 1'b0;
        end else begin
            wr_ptr         <= wr_ptr_next;
            commit_ptr     <= commit_ptr_next;
            // Only whole frames become visible to the read side
            wr_ptr_gray    <= commit_ptr_next ^ (commit_ptr_next >> 1);
            drop_mode      <= drop_next;
            tx_axis_tready <= ready_next;
            good_frame     <= good_next;
            bad_frame      <= bad_next;
            overflow       <= overflow_next;
        end
    end

endmodule

//--- design/frame_fifo_rd.sv
`timescale 1ns/10ps

module frame_fifo_rd (
    input  logic                                 tx_clk,
    input  logic                                 tx_rst,
    input  mac_fifo_pkg::ptr_t                   wr_ptr_sync,
    output mac_fifo_pkg::ptr_t                   rd_ptr_gray,
    output logic [mac_fifo_pkg::fifo_addr_w-1:0] ram_rd_addr,
    input  mac_fifo_pkg::fifo_word_t             ram_rd_word,
    output mac_fifo_pkg::data_t                  mac_tdata,
    output mac_fifo_pkg::keep_t                  mac_tkeep,
    output logic                                 mac_tvalid,
    input  logic                                 mac_tready,
    output logic                                 mac_tlast
);
    import mac_fifo_pkg::*;

    // fetch: RAM word just arrived, hold: RAM word kept by re-reading it
    typedef enum logic [1:0] {rd_idle, rd_fetch, rd_hold} rd_state_t;

    rd_state_t state;
    rd_state_t state_next;
    ptr_t rd_ptr;
    ptr_t rd_ptr_prev;
    ptr_t rd_ptr_next;
    ptr_t done_ptr_next;
    logic ram_valid;
    logic out_free;
    logic avail;
    logic take_ram;
    logic issue;

    assign ram_valid   = state != rd_idle;
    assign out_free    = !mac_tvalid || mac_tready;
    assign avail       = rd_ptr != wr_ptr_sync;
    assign take_ram    = ram_valid && out_free;
    assign issue       = avail && (!ram_valid || take_ram);
    assign rd_ptr_prev = rd_ptr - ptr_t'(1);

    // Point back at the pending word while the output register is busy
    assign ram_rd_addr = (ram_valid && !take_ram) ? rd_ptr_prev[fifo_addr_w-1:0]
                                                  : rd_ptr[fifo_addr_w-1:0];

    always_comb begin
        rd_ptr_next = issue ? rd_ptr + ptr_t'(1) : rd_ptr;
        if (issue) begin
            state_next = rd_fetch;
        end else if (ram_valid && !take_ram) begin
            state_next = rd_hold;
        end else begin
            state_next = rd_idle;
        end
        // A slot stays owned until its word sits in the output register
        done_ptr_next = rd_ptr_next - ptr_t'(state_next != rd_idle);
    end

    always_ff @(posedge tx_clk or posedge tx_rst) begin
        if (tx_rst) begin
            state       <= rd_idle;
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            mac_tvalid  <= 1'b0;
        end else begin
            state       <= state_next;
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= done_ptr_next ^ (done_ptr_next >> 1);
            if (take_ram) begin
                mac_tvalid <= 1'b1;
            end else if (mac_tready) begin
                mac_tvalid <= 1'b0;
            end
        end
    end

    // Output payload toward the MAC
    always_ff @(posedge tx_clk) begin
        if (take_ram) begin
            {mac_tdata, mac_tkeep, mac_tlast} <= ram_rd_word;
        end
    end

endmodule

//--- design/event_sync.sv
`timescale 1ns/10ps

module event_sync (
    input  logic src_clk,
    input  logic src_rst,
    input  logic dst_clk,
    input  logic dst_rst,
    input  logic src_pulse,
    output logic dst_pulse
);

    logic       src_toggle;
    logic [2:0] dst_sync;

    // Each event flips the level
    always_ff @(posedge src_clk or posedge src_rst) begin
        if (src_rst) begin
            src_toggle <= 1'b0;
        end else begin
            src_toggle <= src_toggle ^ src_pulse;
        end
    end

    // First stage resolves metastability, last two detect the edge
    always_ff @(posedge dst_clk or posedge dst_rst) begin
        if (dst_rst) begin
            dst_sync <= 3'b000;
        end else begin
            dst_sync <= {dst_sync[1:0], src_toggle};
        end
    end

    assign dst_pulse = dst_sync[1] ^ dst_sync[2];

endmodule

//--- design/tx_mac_fifo.sv
`timescale 1ns/10ps

module tx_mac_fifo (
    input  logic                logic_clk,
    input  logic                logic_rst,
    input  logic                tx_clk,
    input  logic                tx_rst,

    // User side stream
    input  mac_fifo_pkg::data_t tx_axis_tdata,
    input  mac_fifo_pkg::keep_t tx_axis_tkeep,
    input  logic                tx_axis_tvalid,
    output logic                tx_axis_tready,
    input  logic                tx_axis_tlast,
    input  logic                tx_axis_tuser,

    // MAC side stream
    output mac_fifo_pkg::data_t mac_tdata,
    output mac_fifo_pkg::keep_t mac_tkeep,
    output logic                mac_tvalid,
    input  logic                mac_tready,
    output logic                mac_tlast,
    input  logic                mac_underflow,

    // Status, all in logic_clk
    output logic                tx_error_underflow,
    output logic                tx_fifo_overflow,
    output logic                tx_fifo_bad_frame,
    output logic                tx_fifo_good_frame
);
    import mac_fifo_pkg::*;

    ptr_t                   wr_ptr_gray;
    ptr_t                   wr_ptr_sync;
    ptr_t                   rd_ptr_gray;
    ptr_t                   rd_ptr_sync;
    logic                   ram_wr_en;
    logic [fifo_addr_w-1:0] ram_wr_addr;
    fifo_word_t             ram_wr_word;
    logic [fifo_addr_w-1:0] ram_rd_addr;
    fifo_word_t             ram_rd_word;

    frame_fifo_wr wr_ctrl (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .tx_axis_tdata  (tx_axis_tdata),
        .tx_axis_tkeep  (tx_axis_tkeep),
        .tx_axis_tvalid (tx_axis_tvalid),
        .tx_axis_tready (tx_axis_tready),
        .tx_axis_tlast  (tx_axis_tlast),
        .tx_axis_tuser  (tx_axis_tuser),
        .rd_ptr_sync    (rd_ptr_sync),
        .wr_ptr_gray    (wr_ptr_gray),
        .ram_wr_en      (ram_wr_en),
        .ram_wr_addr    (ram_wr_addr),
        .ram_wr_word    (ram_wr_word),
        .good_frame     (tx_fifo_good_frame),
        .bad_frame      (tx_fifo_bad_frame),
        .overflow       (tx_fifo_overflow)
    );

    fifo_ram ram (
        .logic_clk (logic_clk),
        .tx_clk    (tx_clk),
        .wr_en     (ram_wr_en),
        .wr_addr   (ram_wr_addr),
        .wr_word   (ram_wr_word),
        .rd_addr   (ram_rd_addr),
        .rd_word   (ram_rd_word)
    );

    // Commit pointer into the MAC clock
    gray_ptr_sync wr_ptr_cdc (
        .dst_clk  (tx_clk),
        .dst_rst  (tx_rst),
        .ptr_gray (wr_ptr_gray),
        .ptr_bin  (wr_ptr_sync)
    );

    // Read pointer back into the user clock
    gray_ptr_sync rd_ptr_cdc (
        .dst_clk  (logic_clk),
        .dst_rst  (logic_rst),
        .ptr_gray (rd_ptr_gray),
        .ptr_bin  (rd_ptr_sync)
    );

    frame_fifo_rd rd_ctrl (
        .tx_clk      (tx_clk),
        .tx_rst      (tx_rst),
        .wr_ptr_sync (wr_ptr_sync),
        .rd_ptr_gray (rd_ptr_gray),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_word (ram_rd_word),
        .mac_tdata   (mac_tdata),
        .mac_tkeep   (mac_tkeep),
        .mac_tvalid  (mac_tvalid),
        .mac_tready  (mac_tready),
        .mac_tlast   (mac_tlast)
    );

    event_sync underflow_cdc (
        .src_clk   (tx_clk),
        .src_rst   (tx_rst),
        .dst_clk   (logic_clk),
        .dst_rst   (logic_rst),
        .src_pulse (mac_underflow),
        .dst_pulse (tx_error_underflow)
    );

endmodule

//--- tb/tx_mac_fifo_props.sv
`timescale 1ns/10ps

module tx_mac_fifo_props (
    input logic                logic_clk,
    input logic                logic_rst,
    input logic                tx_clk,
    input logic                tx_rst,
    input logic                tx_axis_tready,
    input mac_fifo_pkg::data_t mac_tdata,
    input mac_fifo_pkg::keep_t mac_tkeep,
    input logic                mac_tvalid,
    input logic                mac_tready,
    input logic                mac_tlast,
    input logic                tx_fifo_good_frame,
    input logic                tx_fifo_bad_frame,
    input logic                tx_fifo_overflow,
    input logic                tx_error_underflow
);

    int fail_count = 0;

    property single_cycle(logic pulse);
        @(posedge logic_clk) disable iff (logic_rst) pulse |=> !pulse;
    endproperty

    // Stalled MAC output holds its word
    mac_hold: assert property (@(posedge tx_clk) disable iff (tx_rst)
        mac_tvalid && !mac_tready |=> mac_tvalid && $stable(mac_tdata) &&
        $stable(mac_tkeep) && $stable(mac_tlast))
        else begin fail_count++; $error("MAC output changed while stalled"); end

    good_pulse: assert property (single_cycle(tx_fifo_good_frame))
        else begin fail_count++; $error("good frame status longer than one cycle"); end
    bad_pulse: assert property (single_cycle(tx_fifo_bad_frame))
        else begin fail_count++; $error("bad frame status longer than one cycle"); end
    overflow_pulse: assert property (single_cycle(tx_fifo_overflow))
        else begin fail_count++; $error("overflow status longer than one cycle"); end
    underflow_pulse: assert property (single_cycle(tx_error_underflow))
        else begin fail_count++; $error("underflow status longer than one cycle"); end

    good_or_bad: assert property (@(posedge logic_clk) !(tx_fifo_good_frame && tx_fifo_bad_frame))
        else begin fail_count++; $error("good and bad frame status together"); end

    ready_in_reset: assert property (@(posedge logic_clk) logic_rst |-> !tx_axis_tready)
        else begin fail_count++; $error("tx_axis_tready high during reset"); end

endmodule

bind tx_mac_fifo tx_mac_fifo_props props (.*);

//--- tb/tx_mac_fifo_tb.sv
`timescale 1ns/10ps

module tx_mac_fifo_tb;
    import mac_fifo_pkg::*;

    localparam int max_len   = 40;
    localparam int block_len = 8;
    localparam int long_len  = 100;

    logic  logic_clk = 1'b0;
    logic  tx_clk = 1'b0;
    logic  logic_rst;
    logic  tx_rst;
    data_t tx_axis_tdata;
    keep_t tx_axis_tkeep;
    logic  tx_axis_tvalid;
    logic  tx_axis_tready;
    logic  tx_axis_tlast;
    logic  tx_axis_tuser;
    data_t mac_tdata;
    keep_t mac_tkeep;
    logic  mac_tvalid;
    logic  mac_tready;
    logic  mac_tlast;
    logic  mac_underflow;
    logic  tx_error_underflow;
    logic  tx_fifo_overflow;
    logic  tx_fifo_bad_frame;
    logic  tx_fifo_good_frame;

    int seed = 84562;
    int ready_mode = 1;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int errors_before = 0;
    int cycles = 0;
    int sent_beats = 0;
    int in_cnt = 0;
    int good_cnt = 0;
    int bad_cnt = 0;
    int ovf_cnt = 0;
    int uf_cnt = 0;

    // Expected MAC side beats, oldest first
    data_t exp_data[$];
    keep_t exp_keep[$];
    logic  exp_last[$];

    tx_mac_fifo dut (.*);

    always #5 logic_clk = ~logic_clk;
    always #3.2 tx_clk = ~tx_clk;

    always @(posedge logic_clk) begin
        cycles++;
        if (cycles > sent_beats * 4 + 2000) begin
            $display("run stopped after %0d cycles, the DUT made no progress", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge logic_clk) begin
        if (tx_axis_tvalid && tx_axis_tready) in_cnt++;
        if (tx_fifo_good_frame) good_cnt++;
        if (tx_fifo_bad_frame) bad_cnt++;
        if (tx_fifo_overflow) ovf_cnt++;
        if (tx_error_underflow) uf_cnt++;
    end

    // MAC side ready, 0 held low, 1 held high, else random
    always @(posedge tx_clk) begin
        #1;
        if (ready_mode == 0) begin
            mac_tready = 1'b0;
        end else if (ready_mode == 1) begin
            mac_tready = 1'b1;
        end else begin
            mac_tready = ($random(seed) % 2) != 0;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge tx_clk) begin
        if (mac_tvalid === 1'b1 && mac_tready === 1'b1) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("beat at the MAC side with no frame expected at %0t", $time);
            end else begin
                check_value("mac_tdata", mac_tdata, exp_data.pop_front());
                check_value("mac_tkeep", mac_tkeep, exp_keep.pop_front());
                check_value("mac_tlast", mac_tlast, exp_last.pop_front());
            end
        end
    end

    function automatic data_t beat_data(input int fseed, input int idx);
        return {fseed, (fseed * 32'h0100_0193) ^ idx};
    endfunction

    // Tail beat carries 1 to 8 valid bytes
    function automatic keep_t last_keep(input int fseed);
        return keep_t'(8'hff >> (7 - fseed[2:0]));
    endfunction

    // Reference model, only good frames that fit reach the MAC
    function automatic void model_frame(input int fseed, input int len, input logic bad);
        if (!bad && len <= fifo_depth) begin
            for (int i = 0; i < len; i++) begin
                exp_data.push_back(beat_data(fseed, i));
                exp_keep.push_back((i == len - 1) ? last_keep(fseed) : '1);
                exp_last.push_back(i == len - 1);
            end
        end
    endfunction

    task automatic send_frame(input int fseed, input int len, input logic bad);
        keep_t tail_keep;
        tail_keep = last_keep(fseed);
        sent_beats += len;
        for (int i = 0; i < len; i++) begin
            tx_axis_tdata  = beat_data(fseed, i);
            tx_axis_tkeep  = (i == len - 1) ? tail_keep : '1;
            tx_axis_tlast  = i == len - 1;
            tx_axis_tuser  = bad && (i == len - 1);
            tx_axis_tvalid = 1'b1;
            // Ready at the falling edge decides the next rising edge
            do begin
                @(negedge logic_clk);
            end while (!tx_axis_tready);
            @(posedge logic_clk);
            #1;
        end
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
        @(negedge logic_clk);
        if (len <= fifo_depth) begin
            if (bad) begin
                check_value("tx_fifo_bad_frame", tx_fifo_bad_frame, 1);
            end else begin
                check_value("tx_fifo_good_frame", tx_fifo_good_frame, 1);
            end
        end
        @(posedge logic_clk);
        #1;
    endtask

    task automatic send_mix(input int count, input int bad_period);
        int   fs;
        int   len;
        logic bad;
        for (int i = 0; i < count; i++) begin
            fs  = $random(seed);
            len = 1 + (($random(seed) & 32'h7fff_ffff) % max_len);
            bad = bad_period > 0 && (i % bad_period == bad_period - 1);
            model_frame(fs, len, bad);
            send_frame(fs, len, bad);
        end
    endtask

    task automatic drain;
        while (exp_data.size() != 0) begin
            @(posedge logic_clk);
        end
        repeat (10) @(posedge logic_clk);
        #1;
    endtask

    task automatic clear_counts;
        in_cnt   = 0;
        good_cnt = 0;
        bad_cnt  = 0;
        ovf_cnt  = 0;
        uf_cnt   = 0;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic pulse_underflow;
        logic seen;
        @(posedge tx_clk);
        #1;
        mac_underflow = 1'b1;
        @(posedge tx_clk);
        seen = 1'b0;
        fork
            begin
                #1;
                mac_underflow = 1'b0;
                repeat (18) @(posedge tx_clk);
            end
            repeat (5) begin
                @(negedge logic_clk);
                seen = seen | tx_error_underflow;
            end
        join
        if (!seen) begin
            errors++;
            $display("no tx_error_underflow within 5 cycles of mac_underflow at %0t", $time);
        end
    endtask

    initial begin
        int fs;
        logic_rst      = 1'b1;
        tx_rst         = 1'b1;
        tx_axis_tdata  = '0;
        tx_axis_tkeep  = '0;
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
        mac_tready     = 1'b0;
        mac_underflow  = 1'b0;
        repeat (2) @(posedge logic_clk);
        @(posedge tx_clk);
        #1;
        logic_rst = 1'b0;
        tx_rst    = 1'b0;
        @(posedge logic_clk);
        #1;

        clear_counts();
        send_mix(20, 0);
        drain();
        check_value("good_frame_count", good_cnt, 20);
        report_test("good frames");

        clear_counts();
        send_mix(12, 3);
        drain();
        check_value("good_frame_count", good_cnt, 8);
        check_value("bad_frame_count", bad_cnt, 4);
        report_test("bad frames");

        clear_counts();
        ready_mode = 2;
        send_mix(15, 0);
        drain();
        ready_mode = 1;
        check_value("good_frame_count", good_cnt, 15);
        report_test("random mac_tready");

        clear_counts();
        ready_mode = 0;
        repeat (4) @(posedge logic_clk);
        #1;
        for (int i = 0; i < fifo_depth / block_len; i++) begin
            fs = $random(seed);
            model_frame(fs, block_len, 1'b0);
            send_frame(fs, block_len, 1'b0);
        end
        fs = $random(seed);
        model_frame(fs, block_len, 1'b0);
        fork
            send_frame(fs, block_len, 1'b0);
            begin
                repeat (40) @(negedge logic_clk);
                check_value("tx_axis_tready", tx_axis_tready, 0);
                // One extra word sits in the MAC output register
                if (in_cnt < fifo_depth || in_cnt > fifo_depth + 2) begin
                    errors++;
                    $display("FIFO took %0d words while the MAC was stalled", in_cnt);
                end
                ready_mode = 1;
            end
        join
        drain();
        check_value("good_frame_count", good_cnt, fifo_depth / block_len + 1);
        report_test("full FIFO");

        clear_counts();
        fs = $random(seed);
        model_frame(fs, long_len, 1'b0);
        send_frame(fs, long_len, 1'b0);
        fs = $random(seed);
        model_frame(fs, 10, 1'b0);
        send_frame(fs, 10, 1'b0);
        drain();
        check_value("overflow_count", ovf_cnt, 1);
        check_value("good_frame_count", good_cnt, 1);
        report_test("oversized frame");

        clear_counts();
        repeat (3) pulse_underflow();
        repeat (10) @(posedge logic_clk);
        check_value("underflow_count", uf_cnt, 3);
        report_test("underflow");

        errors += dut.props.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/mac_fifo_pkg.sv
design/fifo_ram.sv
design/gray_ptr_sync.sv
design/frame_fifo_wr.sv
design/frame_fifo_rd.sv
design/event_sync.sv
design/tx_mac_fifo.sv
tb/tx_mac_fifo_props.sv
tb/tx_mac_fifo_tb.sv

//--- Bender.yml
package:
  name: tx_mac_fifo

sources:
  - design/mac_fifo_pkg.sv
  - design/fifo_ram.sv
  - design/gray_ptr_sync.sv
  - design/frame_fifo_wr.sv
  - design/frame_fifo_rd.sv
  - design/event_sync.sv
  - design/tx_mac_fifo.sv
  - target: test
    files:
      - tb/tx_mac_fifo_props.sv
      - tb/tx_mac_fifo_tb.sv
